// File: rtl/pipeline_macros.svh
`ifndef PIPELINE_MACROS_SVH
`define PIPELINE_MACROS_SVH

`define REG_COUNT 32
`define RESET_PC  32'h1c000000

`define ALU_NOP       6'h00
`define ALU_ADD       6'h01
`define ALU_SUB       6'h02
`define ALU_AND       6'h03
`define ALU_OR        6'h04
`define ALU_XOR       6'h05
`define ALU_SLT       6'h06
`define ALU_SLTU      6'h07
`define ALU_LU12I     6'h08
`define ALU_PCADDU12I 6'h09
`define ALU_LDW       6'h0a
`define ALU_STW       6'h0b
`define ALU_BEQ       6'h0c
`define ALU_BNE       6'h0d
`define ALU_BLT       6'h0e
`define ALU_BGE       6'h0f
`define ALU_BLTU      6'h10
`define ALU_BGEU      6'h11
`define ALU_B         6'h12
`define ALU_BL        6'h13
`define ALU_JIRL      6'h14

`endif

// File: rtl/pipeline_types.sv
package pipeline_types;

    typedef logic [31:0] bus32_t;
    typedef logic [4:0]  reg_addr_t;
    typedef logic [5:0]  alu_op_t; // Holds ALU_* codes

    typedef struct packed {
        logic      valid;
        bus32_t    pc;
        bus32_t    inst;
        alu_op_t   aluop;
        logic      reg1_read_en;
        reg_addr_t reg1_read_addr;
        logic      reg2_read_en;
        reg_addr_t reg2_read_addr;
        bus32_t    imm;
        logic      reg_write_en;
        reg_addr_t reg_write_addr;
    } id_dispatch_t;

    typedef struct packed {
        logic      valid;
        bus32_t    pc;
        alu_op_t   aluop;
        bus32_t    reg1;
        bus32_t    reg2;
        bus32_t    store_data;
        logic      reg_write_en;
        reg_addr_t reg_write_addr;
        bus32_t    reg_write_branch_data; // Link value for BL and JIRL
    } dispatch_ex_t;

    typedef struct packed {
        logic      reg_write_en;
        reg_addr_t reg_write_addr;
        bus32_t    reg_write_data;
    } push_forward_t;

    typedef struct packed {
        logic      valid;
        bus32_t    pc;
        alu_op_t   aluop;
        bus32_t    result; // ALU value or memory address
        bus32_t    store_data;
        logic      reg_write_en;
        reg_addr_t reg_write_addr;
    } ex_result_t;

    typedef struct packed {
        bus32_t    pc;
        logic      reg_write_en;
        reg_addr_t reg_write_addr;
        bus32_t    reg_write_data;
    } commit_t;

    typedef enum logic {WB_IDLE, WB_BUSY} wb_state_t;

endpackage

// File: rtl/decode_stage.sv
`timescale 1ns/10ps
`include "pipeline_macros.svh"

module decode_stage (
    input  logic                         clk,
    input  logic                         rst,
    input  logic                         pause_dispatch,
    input  logic                         branch_flush,
    input  logic                         stall_mem,
    input  pipeline_types::bus32_t       branch_target_addr,
    input  pipeline_types::bus32_t       inst_data,
    output pipeline_types::bus32_t       inst_addr,
    output pipeline_types::id_dispatch_t id_dispatch
);
    import pipeline_types::*;

    bus32_t       pc;
    alu_op_t      aluop;
    reg_addr_t    rd;
    logic         is_3r;
    logic         is_u12;
    logic         is_cond;
    id_dispatch_t dec;

    assign inst_addr = pc;
    assign rd        = inst_data[4:0];

    always_comb begin
        casez (inst_data[31:15])
            17'h00020:              aluop = `ALU_ADD;
            17'h00022:              aluop = `ALU_SUB;
            17'h00024:              aluop = `ALU_SLT;
            17'h00025:              aluop = `ALU_SLTU;
            17'h00029:              aluop = `ALU_AND;
            17'h0002a:              aluop = `ALU_OR;
            17'h0002b:              aluop = `ALU_XOR;
            17'b0000001010_???????: aluop = `ALU_ADD; // ADDI.W
            17'b0010100010_???????: aluop = `ALU_LDW;
            17'b0010100110_???????: aluop = `ALU_STW;
            17'b0001010_??????????: aluop = `ALU_LU12I;
            17'b0001110_??????????: aluop = `ALU_PCADDU12I;
            17'b010011_???????????: aluop = `ALU_JIRL;
            17'b010100_???????????: aluop = `ALU_B;
            17'b010101_???????????: aluop = `ALU_BL;
            17'b010110_???????????: aluop = `ALU_BEQ;
            17'b010111_???????????: aluop = `ALU_BNE;
            17'b011000_???????????: aluop = `ALU_BLT;
            17'b011001_???????????: aluop = `ALU_BGE;
            17'b011010_???????????: aluop = `ALU_BLTU;
            17'b011011_???????????: aluop = `ALU_BGEU;
            default:                aluop = `ALU_NOP; // Becomes a bubble
        endcase
    end

    assign is_3r   = inst_data[31:22] == 10'd0;
    assign is_u12  = (aluop == `ALU_LU12I) || (aluop == `ALU_PCADDU12I);
    assign is_cond = aluop inside {`ALU_BEQ, `ALU_BNE, `ALU_BLT, `ALU_BGE, `ALU_BLTU, `ALU_BGEU};

    always_comb begin
        dec.valid          = aluop != `ALU_NOP;
        dec.pc             = pc;
        dec.inst           = inst_data;
        dec.aluop          = aluop;
        dec.reg1_read_en   = dec.valid && !is_u12 && (aluop != `ALU_B) && (aluop != `ALU_BL);
        dec.reg1_read_addr = inst_data[9:5];
        dec.reg2_read_en   = dec.valid && (is_3r || is_cond || (aluop == `ALU_STW));
        dec.reg2_read_addr = is_3r ? inst_data[14:10] : rd; // rd is a source for stores
        dec.imm            = is_u12 ? {inst_data[24:5], 12'd0}
                                    : {{20{inst_data[21]}}, inst_data[21:10]};
        dec.reg_write_addr = (aluop == `ALU_BL) ? 5'd1 : rd;
        dec.reg_write_en   = dec.valid && !is_cond && (aluop != `ALU_STW)
                             && (aluop != `ALU_B) && (dec.reg_write_addr != 5'd0);
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            pc                <= `RESET_PC;
            id_dispatch.valid <= 1'b0;
        end else if (!stall_mem) begin
            if (branch_flush) begin
                pc                <= branch_target_addr;
                id_dispatch.valid <= 1'b0; // Drop the wrong-path fetch
            end else if (!pause_dispatch) begin
                pc          <= pc + 32'd4;
                id_dispatch <= dec;
            end
        end
    end

endmodule

// File: rtl/regfile.sv
`timescale 1ns/10ps
`include "pipeline_macros.svh"

module regfile (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      reg1_read_en,
    input  logic                      reg2_read_en,
    input  pipeline_types::reg_addr_t reg1_read_addr,
    input  pipeline_types::reg_addr_t reg2_read_addr,
    output pipeline_types::bus32_t    reg1_read_data,
    output pipeline_types::bus32_t    reg2_read_data,
    input  logic                      write_en,
    input  pipeline_types::reg_addr_t write_addr,
    input  pipeline_types::bus32_t    write_data
);
    import pipeline_types::*;

    bus32_t regs [0:`REG_COUNT-1];
    logic   write_live;

    assign write_live = write_en && (write_addr != 5'd0); // r0 stays zero

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < `REG_COUNT; i++) begin
                regs[i] <= '0;
            end
        end else if (write_live) begin
            regs[write_addr] <= write_data;
        end
    end

    assign reg1_read_data = (!reg1_read_en || reg1_read_addr == 5'd0) ? '0 :
                            (write_live && write_addr == reg1_read_addr) ? write_data :
                            regs[reg1_read_addr];
    assign reg2_read_data = (!reg2_read_en || reg2_read_addr == 5'd0) ? '0 :
                            (write_live && write_addr == reg2_read_addr) ? write_data :
                            regs[reg2_read_addr];

endmodule

// File: rtl/dispatch_stage.sv
`timescale 1ns/10ps
`include "pipeline_macros.svh"

module dispatch_stage (
    input  logic                          clk,
    input  logic                          rst,
    input  logic                          stall_mem,
    input  pipeline_types::id_dispatch_t  id_dispatch,
    input  pipeline_types::push_forward_t ex_push_forward,
    input  pipeline_types::push_forward_t mem_push_forward,
    input  pipeline_types::alu_op_t       ex_aluop,
    output logic                          reg1_read_en,
    output logic                          reg2_read_en,
    output pipeline_types::reg_addr_t     reg1_read_addr,
    output pipeline_types::reg_addr_t     reg2_read_addr,
    input  pipeline_types::bus32_t        reg1_read_data,
    input  pipeline_types::bus32_t        reg2_read_data,
    output logic                          pause_dispatch,
    output logic                          branch_flush,
    output pipeline_types::bus32_t        branch_target_addr,
    output pipeline_types::dispatch_ex_t  dispatch_ex
);
    import pipeline_types::*;

    bus32_t op1;
    bus32_t op2;
    bus32_t offs16;
    bus32_t offs26;
    logic   load_in_ex;
    logic   taken;

    function automatic bus32_t pick_operand(
        input logic          en,
        input reg_addr_t     addr,
        input bus32_t        rf_data,
        input bus32_t        imm,
        input push_forward_t ex_fwd,
        input push_forward_t mem_fwd
    );
        if (!en) begin
            pick_operand = imm;
        end else if (addr != 5'd0 && ex_fwd.reg_write_en && ex_fwd.reg_write_addr == addr) begin
            pick_operand = ex_fwd.reg_write_data; // Youngest producer wins
        end else if (addr != 5'd0 && mem_fwd.reg_write_en
                     && mem_fwd.reg_write_addr == addr) begin
            pick_operand = mem_fwd.reg_write_data;
        end else begin
            pick_operand = rf_data;
        end
    endfunction

    assign reg1_read_en   = id_dispatch.reg1_read_en;
    assign reg1_read_addr = id_dispatch.reg1_read_addr;
    assign reg2_read_en   = id_dispatch.reg2_read_en;
    assign reg2_read_addr = id_dispatch.reg2_read_addr;

    assign op1 = (id_dispatch.aluop == `ALU_PCADDU12I) ? id_dispatch.pc :
                 pick_operand(reg1_read_en, reg1_read_addr, reg1_read_data, id_dispatch.imm,
                              ex_push_forward, mem_push_forward);
    assign op2 = pick_operand(reg2_read_en, reg2_read_addr, reg2_read_data, id_dispatch.imm,
                              ex_push_forward, mem_push_forward);

    // Load data only exists after the bus cycle
    assign load_in_ex     = (ex_aluop == `ALU_LDW) && (ex_push_forward.reg_write_addr != 5'd0);
    assign pause_dispatch = id_dispatch.valid && load_in_ex
        && ((reg1_read_en && ex_push_forward.reg_write_addr == reg1_read_addr)
        ||  (reg2_read_en && ex_push_forward.reg_write_addr == reg2_read_addr));

    assign offs16 = {{14{id_dispatch.inst[25]}}, id_dispatch.inst[25:10], 2'b00};
    assign offs26 = {{4{id_dispatch.inst[9]}}, id_dispatch.inst[9:0],
                     id_dispatch.inst[25:10], 2'b00};

    always_comb begin
        taken              = 1'b0;
        branch_target_addr = id_dispatch.pc + offs16;
        case (id_dispatch.aluop)
            `ALU_BEQ:  taken = op1 == op2;
            `ALU_BNE:  taken = op1 != op2;
            `ALU_BLT:  taken = $signed(op1) < $signed(op2);
            `ALU_BGE:  taken = $signed(op1) >= $signed(op2);
            `ALU_BLTU: taken = op1 < op2;
            `ALU_BGEU: taken = op1 >= op2;
            `ALU_B, `ALU_BL: begin
                taken              = 1'b1;
                branch_target_addr = id_dispatch.pc + offs26;
            end
            `ALU_JIRL: begin
                taken              = 1'b1;
                branch_target_addr = op1 + offs16; // Register relative
            end
            default: taken = 1'b0;
        endcase
    end

    assign branch_flush = id_dispatch.valid && taken && !pause_dispatch;

    always_ff @(posedge clk) begin
        if (rst) begin
            dispatch_ex.valid <= 1'b0;
        end else if (!stall_mem) begin
            dispatch_ex.valid                 <= id_dispatch.valid && !pause_dispatch;
            dispatch_ex.pc                    <= id_dispatch.pc;
            dispatch_ex.aluop                 <= id_dispatch.aluop;
            dispatch_ex.reg1                  <= op1;
            dispatch_ex.reg2                  <= (id_dispatch.aluop == `ALU_STW) ?
                                                 id_dispatch.imm : op2;
            dispatch_ex.store_data            <= op2;
            dispatch_ex.reg_write_en          <= id_dispatch.reg_write_en;
            dispatch_ex.reg_write_addr        <= id_dispatch.reg_write_addr;
            dispatch_ex.reg_write_branch_data <= id_dispatch.pc + 32'd4;
        end
    end

endmodule

// File: rtl/execute_stage.sv
`timescale 1ns/10ps
`include "pipeline_macros.svh"

module execute_stage (
    input  logic                          clk,
    input  logic                          rst,
    input  logic                          stall_mem,
    input  pipeline_types::dispatch_ex_t  dispatch_ex,
    output pipeline_types::push_forward_t ex_push_forward,
    output pipeline_types::alu_op_t       ex_aluop,
    output pipeline_types::ex_result_t    ex_result
);
    import pipeline_types::*;

    bus32_t alu;
    logic   is_load;

    always_comb begin
        case (dispatch_ex.aluop)
            `ALU_ADD, `ALU_PCADDU12I,
            `ALU_LDW, `ALU_STW: alu = dispatch_ex.reg1 + dispatch_ex.reg2; // Address for memory ops
            `ALU_SUB:           alu = dispatch_ex.reg1 - dispatch_ex.reg2;
            `ALU_AND:           alu = dispatch_ex.reg1 & dispatch_ex.reg2;
            `ALU_OR:            alu = dispatch_ex.reg1 | dispatch_ex.reg2;
            `ALU_XOR:           alu = dispatch_ex.reg1 ^ dispatch_ex.reg2;
            `ALU_SLT:           alu = {31'd0, $signed(dispatch_ex.reg1) < $signed(dispatch_ex.reg2)};
            `ALU_SLTU:          alu = {31'd0, dispatch_ex.reg1 < dispatch_ex.reg2};
            `ALU_LU12I:         alu = dispatch_ex.reg2;
            `ALU_BL, `ALU_JIRL: alu = dispatch_ex.reg_write_branch_data;
            default:            alu = '0;
        endcase
    end

    assign is_load  = dispatch_ex.aluop == `ALU_LDW;
    assign ex_aluop = dispatch_ex.valid ? dispatch_ex.aluop : `ALU_NOP;

    assign ex_push_forward = '{
        reg_write_en:   dispatch_ex.valid && dispatch_ex.reg_write_en && !is_load,
        reg_write_addr: dispatch_ex.reg_write_addr,
        reg_write_data: alu
    };

    always_ff @(posedge clk) begin
        if (rst) begin
            ex_result.valid <= 1'b0;
        end else if (!stall_mem) begin
            ex_result.valid          <= dispatch_ex.valid;
            ex_result.pc             <= dispatch_ex.pc;
            ex_result.aluop          <= dispatch_ex.aluop;
            ex_result.result         <= alu;
            ex_result.store_data     <= dispatch_ex.store_data;
            ex_result.reg_write_en   <= dispatch_ex.reg_write_en;
            ex_result.reg_write_addr <= dispatch_ex.reg_write_addr;
        end
    end

endmodule

// File: rtl/result_stage.sv
`timescale 1ns/10ps
`include "pipeline_macros.svh"

module result_stage (
    input  logic                          clk,
    input  logic                          rst,
    input  pipeline_types::ex_result_t    ex_result,
    output logic                          stall_mem,
    output pipeline_types::push_forward_t mem_push_forward,
    output logic                          wb_cyc,
    output logic                          wb_stb,
    output logic                          wb_we,
    output pipeline_types::bus32_t        wb_adr,
    output pipeline_types::bus32_t        wb_dat_w,
    output logic [3:0]                    wb_sel,
    input  pipeline_types::bus32_t        wb_dat_r,
    input  logic                          wb_ack,
    output logic                          write_en,
    output pipeline_types::reg_addr_t     write_addr,
    output pipeline_types::bus32_t        write_data,
    output logic                          commit_valid,
    output pipeline_types::commit_t       commit
);
    import pipeline_types::*;

    wb_state_t state;
    logic      is_load;
    logic      is_store;
    logic      done;

    assign is_load  = ex_result.valid && (ex_result.aluop == `ALU_LDW);
    assign is_store = ex_result.valid && (ex_result.aluop == `ALU_STW);

    // Hold the pipe from issue until the slave acks
    assign stall_mem = (is_load || is_store) && ((state == WB_IDLE) || !wb_ack);
    assign done      = ex_result.valid && !stall_mem;

    assign wb_cyc   = state == WB_BUSY;
    assign wb_stb   = wb_cyc;
    assign wb_we    = wb_cyc && is_store;
    assign wb_adr   = ex_result.result; // Stable while stalled
    assign wb_dat_w = ex_result.store_data;
    assign wb_sel   = 4'hf;

    assign write_en   = done && ex_result.reg_write_en;
    assign write_addr = ex_result.reg_write_addr;
    assign write_data = is_load ? wb_dat_r : ex_result.result;

    assign mem_push_forward = '{
        reg_write_en:   write_en,
        reg_write_addr: write_addr,
        reg_write_data: write_data
    };

    always_ff @(posedge clk) begin
        if (rst) begin
            state        <= WB_IDLE;
            commit_valid <= 1'b0;
        end else begin
            case (state)
                WB_IDLE: if (is_load || is_store) state <= WB_BUSY;
                WB_BUSY: if (wb_ack) state <= WB_IDLE; // cyc drops next cycle
                default: state <= WB_IDLE;
            endcase
            commit_valid <= done;
        end
    end

    always_ff @(posedge clk) begin
        if (done) begin
            commit <= '{pc: ex_result.pc, reg_write_en: write_en,
                        reg_write_addr: write_addr, reg_write_data: write_data};
        end
    end

endmodule

// File: rtl/core_top.sv
`timescale 1ns/10ps

module core_top (
    input  logic                    clk,
    input  logic                    rst,
    output pipeline_types::bus32_t  inst_addr,
    input  pipeline_types::bus32_t  inst_data,
    output logic                    wb_cyc,
    output logic                    wb_stb,
    output logic                    wb_we,
    output pipeline_types::bus32_t  wb_adr,
    output pipeline_types::bus32_t  wb_dat_w,
    output logic [3:0]              wb_sel,
    input  pipeline_types::bus32_t  wb_dat_r,
    input  logic                    wb_ack,
    output logic                    commit_valid,
    output pipeline_types::commit_t commit
);
    import pipeline_types::*;

    id_dispatch_t  id_dispatch;
    dispatch_ex_t  dispatch_ex;
    ex_result_t    ex_result;
    push_forward_t ex_push_forward;
    push_forward_t mem_push_forward;
    alu_op_t       ex_aluop;
    logic          pause_dispatch;
    logic          branch_flush;
    logic          stall_mem;
    bus32_t        branch_target_addr;
    logic          reg1_read_en;
    logic          reg2_read_en;
    reg_addr_t     reg1_read_addr;
    reg_addr_t     reg2_read_addr;
    bus32_t        reg1_read_data;
    bus32_t        reg2_read_data;
    logic          write_en;
    reg_addr_t     write_addr;
    bus32_t        write_data;

    // Port names match the nets one to one
    decode_stage u_decode (.*);

    regfile u_regfile (.*);

    dispatch_stage u_dispatch (.*);

    execute_stage u_execute (.*);

    result_stage u_result (.*);

endmodule

// File: dv/core_properties.sv
`timescale 1ns/10ps
`include "pipeline_macros.svh"

module core_properties (
    input logic                    clk,
    input logic                    rst,
    input pipeline_types::bus32_t  inst_addr,
    input logic                    wb_cyc,
    input logic                    wb_stb,
    input logic                    wb_we,
    input pipeline_types::bus32_t  wb_adr,
    input pipeline_types::bus32_t  wb_dat_w,
    input logic [3:0]              wb_sel,
    input logic                    wb_ack,
    input logic                    commit_valid,
    input pipeline_types::commit_t commit,
    input pipeline_types::commit_t exp_commit,
    input logic                    exp_store,
    input pipeline_types::bus32_t  exp_st_adr,
    input pipeline_types::bus32_t  exp_st_dat
);

    int unsigned fail_count = 0;

    commit_pc: assert property (@(posedge clk) disable iff (rst)
        commit_valid |-> commit.pc == exp_commit.pc)
        else begin
            $error("mismatch at %0t: commit pc %h, expected %h", $time,
                   $sampled(commit.pc), $sampled(exp_commit.pc));
            fail_count++;
        end

    // Address and data only matter when a register is written
    commit_write: assert property (@(posedge clk) disable iff (rst)
        commit_valid |-> commit.reg_write_en == exp_commit.reg_write_en
            && (!exp_commit.reg_write_en
                || (commit.reg_write_addr == exp_commit.reg_write_addr
                    && commit.reg_write_data == exp_commit.reg_write_data)))
        else begin
            $error("mismatch at %0t: write at pc %h is r%0d=%h, expected r%0d=%h", $time,
                   $sampled(commit.pc), $sampled(commit.reg_write_addr),
                   $sampled(commit.reg_write_data), $sampled(exp_commit.reg_write_addr),
                   $sampled(exp_commit.reg_write_data));
            fail_count++;
        end

    no_r0_write: assert property (@(posedge clk) disable iff (rst)
        commit_valid |-> !(commit.reg_write_en && commit.reg_write_addr == 5'd0))
        else begin
            $error("commit at %0t writes register r0", $time);
            fail_count++;
        end

    store_bus: assert property (@(posedge clk) disable iff (rst)
        wb_cyc && wb_ack |-> wb_we == exp_store
            && (!exp_store || (wb_adr == exp_st_adr && wb_dat_w == exp_st_dat)))
        else begin
            $error("mismatch at %0t: bus we=%b adr %h dat %h, expected we=%b adr %h dat %h",
                   $time, $sampled(wb_we), $sampled(wb_adr), $sampled(wb_dat_w),
                   $sampled(exp_store), $sampled(exp_st_adr), $sampled(exp_st_dat));
            fail_count++;
        end

    // Word access only
    word_select: assert property (@(posedge clk) disable iff (rst)
        wb_cyc |-> wb_sel == 4'hf)
        else begin
            $error("mismatch at %0t: wb_sel %h, expected f", $time, $sampled(wb_sel));
            fail_count++;
        end

    cyc_with_stb: assert property (@(posedge clk) disable iff (rst)
        (wb_cyc || wb_stb) |-> wb_cyc && wb_stb && !commit_valid)
        else begin
            $error("Wishbone cyc and stb differ, or a commit happened during a bus cycle");
            fail_count++;
        end

    hold_until_ack: assert property (@(posedge clk) disable iff (rst)
        wb_cyc && !wb_ack |=> wb_cyc && $stable(wb_adr) && $stable(wb_we)
            && $stable(wb_dat_w))
        else begin
            $error("Wishbone request dropped or changed before ack");
            fail_count++;
        end

    drop_after_ack: assert property (@(posedge clk) disable iff (rst)
        wb_cyc && wb_ack |=> !wb_cyc)
        else begin
            $error("Wishbone cycle still open in the cycle after ack");
            fail_count++;
        end

    reset_state: assert property (@(posedge clk)
        $fell(rst) |-> !wb_cyc && !wb_stb && !commit_valid && inst_addr == `RESET_PC)
        else begin
            $error("outputs not in their reset state after reset release");
            fail_count++;
        end

endmodule

// File: dv/core_tb.sv
`timescale 1ns/10ps
`include "pipeline_macros.svh"

module core_tb;
    import pipeline_types::*;

    localparam int     PROG_WORDS     = 64;
    localparam int     DATA_WORDS     = 64;
    localparam int     TIMEOUT_CYCLES = 2000;
    localparam bus32_t END_PC         = `RESET_PC + 32'd132; // Self-loop at word 33

    logic       clk = 1'b0;
    logic       rst;
    bus32_t     inst_addr;
    bus32_t     inst_data;
    logic       wb_cyc;
    logic       wb_stb;
    logic       wb_we;
    bus32_t     wb_adr;
    bus32_t     wb_dat_w;
    logic [3:0] wb_sel;
    bus32_t     wb_dat_r = '0;
    logic       wb_ack = 1'b0;
    logic       commit_valid;
    commit_t    commit;

    bus32_t  imem [0:PROG_WORDS-1];
    bus32_t  dmem [0:DATA_WORDS-1];
    bus32_t  gmem [0:DATA_WORDS-1];
    bus32_t  gregs [0:31];
    bus32_t  gpc;
    bus32_t  exp_next;
    commit_t exp_commit;
    logic    exp_store;
    bus32_t  exp_st_adr;
    bus32_t  exp_st_dat;
    int      ack_wait = -1;
    int      timeouts = 0;

    core_top UUT (.*);

    bind core_top core_properties u_props (
        .*,
        .exp_commit(core_tb.exp_commit),
        .exp_store (core_tb.exp_store),
        .exp_st_adr(core_tb.exp_st_adr),
        .exp_st_dat(core_tb.exp_st_dat)
    );

    always #4 clk = ~clk;

    function automatic bus32_t three_reg(input logic [16:0] op, input int rd, rj, rk);
        three_reg = {op, rk[4:0], rj[4:0], rd[4:0]};
    endfunction

    function automatic bus32_t reg_imm12(input logic [9:0] op, input int rd, rj, imm);
        reg_imm12 = {op, imm[11:0], rj[4:0], rd[4:0]};
    endfunction

    function automatic bus32_t upper_imm20(input logic [6:0] op, input int rd, imm);
        upper_imm20 = {op, imm[19:0], rd[4:0]};
    endfunction

    function automatic bus32_t branch16(input logic [5:0] op, input int rj, rd, offs);
        branch16 = {op, offs[15:0], rj[4:0], rd[4:0]};
    endfunction

    function automatic bus32_t jump26(input logic [5:0] op, input int offs);
        jump26 = {op, offs[15:0], offs[25:16]};
    endfunction

    function automatic bus32_t prog_word(input bus32_t addr);
        bus32_t idx;
        idx       = (addr - `RESET_PC) >> 2;
        prog_word = (idx < PROG_WORDS) ? imem[idx] : 32'd0; // Zero decodes as a bubble
    endfunction

    function automatic int word_index(input bus32_t addr);
        word_index = (addr >> 2) % DATA_WORDS;
    endfunction

    function automatic bus32_t fill_word(input bus32_t addr);
        fill_word = (addr * 32'h0001_0003) ^ 32'h3c5a_96e1;
    endfunction

    function automatic logic branch_taken(input logic [5:0] op, input bus32_t a, input bus32_t b);
        case (op)
            6'h16:   branch_taken = a == b;
            6'h17:   branch_taken = a != b;
            6'h18:   branch_taken = $signed(a) < $signed(b);
            6'h19:   branch_taken = $signed(a) >= $signed(b);
            6'h1a:   branch_taken = a < b;
            default: branch_taken = a >= b; // BGEU
        endcase
    endfunction

    task automatic load_program();
        for (int i = 0; i < PROG_WORDS; i++) begin
            imem[i] = '0;
        end
        imem[0]  = reg_imm12(10'h00a, 1, 0, 5);
        imem[1]  = reg_imm12(10'h00a, 2, 1, -8);   // r2 = -3, back to back
        imem[2]  = three_reg(17'h00020, 3, 1, 2);
        imem[3]  = three_reg(17'h00022, 4, 3, 2);
        imem[4]  = three_reg(17'h00029, 5, 4, 2);
        imem[5]  = three_reg(17'h0002a, 6, 5, 1);
        imem[6]  = three_reg(17'h0002b, 7, 6, 2);
        imem[7]  = three_reg(17'h00024, 8, 2, 1);
        imem[8]  = three_reg(17'h00025, 9, 2, 1);
        imem[9]  = upper_imm20(7'h0a, 10, 'h12345);
        imem[10] = upper_imm20(7'h0e, 11, 1);
        imem[11] = reg_imm12(10'h00a, 0, 1, 7);    // Write to r0 is dropped
        imem[12] = three_reg(17'h00020, 12, 0, 1);
        imem[13] = reg_imm12(10'h0a6, 12, 0, 'h20); // Store data forwarded
        imem[14] = reg_imm12(10'h0a2, 13, 0, 'h20);
        imem[15] = three_reg(17'h00020, 14, 13, 1); // Load-use pair
        imem[16] = reg_imm12(10'h0a2, 15, 0, 'h44);
        imem[17] = branch16(6'h18, 2, 1, 2);       // BLT taken on -3
        imem[18] = reg_imm12(10'h00a, 16, 0, 1);
        imem[19] = branch16(6'h1a, 2, 1, 2);       // BLTU not taken
        imem[20] = reg_imm12(10'h00a, 17, 0, 2);
        imem[21] = branch16(6'h19, 1, 2, 2);
        imem[22] = reg_imm12(10'h00a, 16, 0, 3);
        imem[23] = branch16(6'h1b, 2, 1, 2);
        imem[24] = reg_imm12(10'h00a, 16, 0, 4);
        imem[25] = branch16(6'h16, 1, 4, 2);
        imem[26] = reg_imm12(10'h00a, 16, 0, 5);
        imem[27] = branch16(6'h17, 1, 4, 2);
        imem[28] = jump26(6'h15, 3);               // BL to word 31
        imem[29] = reg_imm12(10'h00a, 18, 15, 1);  // Return point of JIRL
        imem[30] = jump26(6'h14, 3);
        imem[31] = reg_imm12(10'h00a, 19, 1, 0);
        imem[32] = branch16(6'h13, 1, 20, 0);      // JIRL r20, r1, 0
        imem[33] = jump26(6'h14, 0);
    endtask

    always_comb inst_data = prog_word(inst_addr);

    // Wishbone slave with 0 to 3 wait states
    always @(negedge clk) begin
        wb_ack <= 1'b0;
        if (rst) begin
            ack_wait = -1;
            for (int i = 0; i < DATA_WORDS; i++) begin
                dmem[i] <= fill_word(i * 4);
            end
        end else if (wb_cyc && wb_stb) begin
            if (ack_wait < 0) begin
                ack_wait = $urandom % 4;
            end
            if (ack_wait == 0) begin
                wb_ack <= 1'b1;
                if (wb_we) begin
                    dmem[word_index(wb_adr)] <= wb_dat_w;
                end else begin
                    wb_dat_r <= dmem[word_index(wb_adr)];
                end
            end
            ack_wait = ack_wait - 1;
        end
    end

    // Golden model of the next instruction to retire
    always_comb begin
        bus32_t    inst;
        bus32_t    rj;
        bus32_t    rk;
        bus32_t    rd;
        bus32_t    si12;
        bus32_t    offs16;
        bus32_t    offs26;
        bus32_t    data;
        reg_addr_t dst;
        logic      wr;
        inst       = prog_word(gpc);
        rj         = gregs[inst[9:5]];
        rk         = gregs[inst[14:10]];
        rd         = gregs[inst[4:0]];
        si12       = {{20{inst[21]}}, inst[21:10]};
        offs16     = {{14{inst[25]}}, inst[25:10], 2'b00};
        offs26     = {{4{inst[9]}}, inst[9:0], inst[25:10], 2'b00};
        data       = '0;
        dst        = inst[4:0];
        wr         = 1'b1;
        exp_next   = gpc + 32'd4;
        exp_store  = 1'b0;
        exp_st_adr = rj + si12;
        exp_st_dat = rd;
        casez (inst[31:15])
            17'h00020:              data = rj + rk;
            17'h00022:              data = rj - rk;
            17'h00024:              data = {31'd0, $signed(rj) < $signed(rk)};
            17'h00025:              data = {31'd0, rj < rk};
            17'h00029:              data = rj & rk;
            17'h0002a:              data = rj | rk;
            17'h0002b:              data = rj ^ rk;
            17'b0000001010_???????: data = rj + si12;
            17'b0010100010_???????: data = gmem[word_index(rj + si12)];
            17'b0001010_??????????: data = {inst[24:5], 12'd0};
            17'b0001110_??????????: data = gpc + {inst[24:5], 12'd0};
            17'b0010100110_???????: begin
                wr        = 1'b0;
                exp_store = 1'b1;
            end
            17'b010011_???????????: begin
                data     = gpc + 32'd4;
                exp_next = rj + offs16;
            end
            17'b010100_???????????: begin
                wr       = 1'b0;
                exp_next = gpc + offs26;
            end
            17'b010101_???????????: begin
                data     = gpc + 32'd4;
                dst      = 5'd1; // BL links to r1
                exp_next = gpc + offs26;
            end
            17'b01011?_???????????, 17'b0110??_???????????: begin
                wr = 1'b0;
                if (branch_taken(inst[31:26], rj, rd)) begin
                    exp_next = gpc + offs16;
                end
            end
            default: wr = 1'b0;
        endcase
        exp_commit.pc             = gpc;
        exp_commit.reg_write_en   = wr && (dst != 5'd0);
        exp_commit.reg_write_addr = dst;
        exp_commit.reg_write_data = data;
    end

    always @(posedge clk) begin
        if (rst) begin
            gpc <= `RESET_PC;
            for (int i = 0; i < 32; i++) begin
                gregs[i] <= '0;
            end
            for (int i = 0; i < DATA_WORDS; i++) begin
                gmem[i] <= fill_word(i * 4);
            end
        end else if (commit_valid) begin
            gpc <= exp_next;
            if (exp_commit.reg_write_en) begin
                gregs[exp_commit.reg_write_addr] <= exp_commit.reg_write_data;
            end
            if (exp_store) begin
                gmem[word_index(exp_st_adr)] <= exp_st_dat;
            end
        end
    end

    initial begin
        int cycles;
        void'($urandom(32'hf60));
        rst = 1'b1;
        load_program();
        repeat (2) @(posedge clk);
        @(negedge clk);
        rst    = 1'b0;
        cycles = 0;
        while (!(commit_valid && commit.pc == END_PC) && cycles < TIMEOUT_CYCLES) begin
            @(negedge clk);
            cycles++;
        end
        if (cycles >= TIMEOUT_CYCLES) begin
            timeouts++;
            $display("timeout: end marker not committed within %0d cycles", TIMEOUT_CYCLES);
        end
        @(negedge clk); // Let the last commit be sampled
        $display("errors: %0d assertion failures, %0d timeouts",
                 UUT.u_props.fail_count, timeouts);
        if (UUT.u_props.fail_count == 0 && timeouts == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule

// File: compile.f
+incdir+rtl
rtl/pipeline_types.sv
rtl/decode_stage.sv
rtl/regfile.sv
rtl/dispatch_stage.sv
rtl/execute_stage.sv
rtl/result_stage.sv
rtl/core_top.sv
dv/core_properties.sv
dv/core_tb.sv

// File: Bender.yml
package:
  name: core_pipeline

sources:
  - include_dirs:
      - rtl
    files:
      - rtl/pipeline_types.sv
      - rtl/decode_stage.sv
      - rtl/regfile.sv
      - rtl/dispatch_stage.sv
      - rtl/execute_stage.sv
      - rtl/result_stage.sv
      - rtl/core_top.sv
  - target: simulation
    include_dirs:
      - rtl
    files:
      - dv/core_properties.sv
      - dv/core_tb.sv
